// File: evict_pkg.sv
package evict_pkg;

	// Default widths for the eviction path.
	localparam int ADDR_WIDTH_D = 32;
	localparam int DATA_WIDTH_D = 64;
	localparam int ID_WIDTH_D   = 4;

	// Width of the saturating B error counter.
	localparam int ERR_WIDTH    = 8;

	// All eviction traffic uses one fixed AXI ID.
	localparam logic [ID_WIDTH_D-1:0] EVICT_ID = 4'h3;

	// B channel response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: evict_fifo.sv
`timescale 1ns/1ps

module evict_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             wr_en_i,
	input  logic [WIDTH-1:0] wr_data_i,
	output logic             full_o,

	input  logic             rd_en_i,
	output logic [WIDTH-1:0] rd_data_o,
	output logic             empty_o
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic [WIDTH-1:0]     rd_data_q;

	logic                 do_wr;
	logic                 do_rd;

	assign do_wr = wr_en_i && !full_o;
	assign do_rd = rd_en_i && !empty_o;

	assign full_o    = (count == CNT_WIDTH'(DEPTH));
	assign empty_o   = (count == '0);
	assign rd_data_o = rd_data_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				if (wr_ptr == PTR_WIDTH'(DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_rd) begin
				if (rd_ptr == PTR_WIDTH'(DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Simultaneous push and pop leaves the count alone.
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	// Read data lands one cycle after rd_en.
	always_ff @(posedge clk) begin
		if (do_rd) begin
			rd_data_q <= mem[rd_ptr];
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_en_i && full_o))
		else $error("FIFO written while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_en_i && empty_o))
		else $error("FIFO read while empty");

endmodule

// File: evict_aw_w.sv
`timescale 1ns/1ps

module evict_aw_w #(
	parameter int ADDR_WIDTH = evict_pkg::ADDR_WIDTH_D,
	parameter int DATA_WIDTH = evict_pkg::DATA_WIDTH_D,
	parameter int ID_WIDTH   = evict_pkg::ID_WIDTH_D
) (
	input  logic                  clk,
	input  logic                  rst_n,

	output logic [ID_WIDTH-1:0]   awid_o,
	output logic [ADDR_WIDTH-1:0] awaddr_o,
	output logic                  awvalid_o,
	input  logic                  awready_i,

	output logic [ID_WIDTH-1:0]   wid_o,
	output logic [DATA_WIDTH-1:0] wdata_o,
	output logic                  wvalid_o,
	input  logic                  wready_i,

	input  logic                  afifo_empty_i,
	output logic                  afifo_rd_en_o,
	input  logic [ADDR_WIDTH-1:0] afifo_data_i,

	input  logic                  dfifo_empty_i,
	output logic                  dfifo_rd_en_o,
	input  logic [DATA_WIDTH-1:0] dfifo_data_i,

	input  logic                  credit_ok_i,
	output logic                  aw_fire_o
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_READ = 2'd1;
	localparam logic [1:0] S_LOAD = 2'd2;
	localparam logic [1:0] S_SEND = 2'd3;

	logic [1:0]            state;
	logic [1:0]            state_n;
	logic                  awvalid_q;
	logic                  awvalid_n;
	logic                  wvalid_q;
	logic                  wvalid_n;
	logic                  aw_done;
	logic                  aw_done_n;
	logic                  w_done;
	logic                  w_done_n;
	logic [ADDR_WIDTH-1:0] awaddr_q;
	logic [DATA_WIDTH-1:0] wdata_q;

	logic                  aw_hs;
	logic                  w_hs;

	assign aw_hs = awvalid_q && awready_i;
	assign w_hs  = wvalid_q && wready_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			aw_done   <= 1'b0;
			w_done    <= 1'b0;
		end else begin
			state     <= state_n;
			awvalid_q <= awvalid_n;
			wvalid_q  <= wvalid_n;
			aw_done   <= aw_done_n;
			w_done    <= w_done_n;
		end
	end

	// Payload is captured from the FIFO outputs in LOAD.
	always_ff @(posedge clk) begin
		if (state == S_LOAD) begin
			awaddr_q <= afifo_data_i;
			wdata_q  <= dfifo_data_i;
		end
	end

	always_comb begin
		state_n   = state;
		awvalid_n = awvalid_q;
		wvalid_n  = wvalid_q;
		aw_done_n = aw_done;
		w_done_n  = w_done;

		case (state)
			S_IDLE: begin
				if (!afifo_empty_i && !dfifo_empty_i && credit_ok_i) begin
					state_n = S_READ;
				end
			end
			S_READ: begin
				state_n = S_LOAD;
			end
			S_LOAD: begin
				awvalid_n = 1'b1;
				wvalid_n  = 1'b1;
				aw_done_n = 1'b0;
				w_done_n  = 1'b0;
				state_n   = S_SEND;
			end
			S_SEND: begin
				if (aw_hs) begin
					awvalid_n = 1'b0;
					aw_done_n = 1'b1;
				end
				if (w_hs) begin
					wvalid_n = 1'b0;
					w_done_n = 1'b1;
				end
				// Channels finish independently and in either order.
				if ((aw_done || aw_hs) && (w_done || w_hs)) begin
					state_n = S_IDLE;
				end
			end
			default: begin
				state_n = S_IDLE;
			end
		endcase
	end

	assign afifo_rd_en_o = (state == S_READ);
	assign dfifo_rd_en_o = (state == S_READ);

	assign awid_o    = evict_pkg::EVICT_ID;
	assign awaddr_o  = awaddr_q;
	assign awvalid_o = awvalid_q;

	assign wid_o     = evict_pkg::EVICT_ID;
	assign wdata_o   = wdata_q;
	assign wvalid_o  = wvalid_q;

	assign aw_fire_o = aw_hs;

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
		else $error("AW payload changed before acceptance");

	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
		else $error("W payload changed before acceptance");

endmodule

// File: evict_b_track.sv
`timescale 1ns/1ps

module evict_b_track #(
	parameter int ID_WIDTH        = evict_pkg::ID_WIDTH_D,
	parameter int MAX_OUTSTANDING = 4,
	parameter int CNT_WIDTH       = $clog2(MAX_OUTSTANDING + 1)
) (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic                           aw_fire_i,

	input  logic [ID_WIDTH-1:0]            bid_i,
	input  logic [1:0]                     bresp_i,
	input  logic                           bvalid_i,
	output logic                           bready_o,

	output logic                           credit_ok_o,
	output logic [CNT_WIDTH-1:0]           outstanding_o,
	output logic [evict_pkg::ERR_WIDTH-1:0] err_count_o
);

	logic                            bready_q;
	logic [CNT_WIDTH-1:0]            outstanding_q;
	logic [evict_pkg::ERR_WIDTH-1:0] err_q;
	logic                            b_acc;

	assign b_acc = bvalid_i && bready_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bready_q      <= 1'b0;
			outstanding_q <= '0;
			err_q         <= '0;
		end else begin
			bready_q <= 1'b1;
			case ({aw_fire_i, b_acc})
				2'b10:   outstanding_q <= outstanding_q + 1'b1;
				2'b01:   outstanding_q <= outstanding_q - 1'b1;
				default: outstanding_q <= outstanding_q;
			endcase
			// Saturates at all ones.
			if (b_acc && (bresp_i != evict_pkg::RESP_OKAY) && (err_q != '1)) begin
				err_q <= err_q + 1'b1;
			end
		end
	end

	assign bready_o      = bready_q;
	assign credit_ok_o   = (outstanding_q < CNT_WIDTH'(MAX_OUTSTANDING));
	assign outstanding_o = outstanding_q;
	assign err_count_o   = err_q;

	a_no_orphan_b: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid_i |-> (outstanding_q != '0))
		else $error("B response with no write outstanding");

	a_max_out: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding_q <= CNT_WIDTH'(MAX_OUTSTANDING))
		else $error("Outstanding writes above limit");

	a_bid: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid_i |-> (bid_i == ID_WIDTH'(evict_pkg::EVICT_ID)))
		else $error("Unexpected B ID");

endmodule

// File: evict_top.sv
`timescale 1ns/1ps

module evict_top #(
	parameter int ADDR_WIDTH      = evict_pkg::ADDR_WIDTH_D,
	parameter int DATA_WIDTH      = evict_pkg::DATA_WIDTH_D,
	parameter int ID_WIDTH        = evict_pkg::ID_WIDTH_D,
	parameter int FIFO_DEPTH      = 8,
	parameter int MAX_OUTSTANDING = 4,
	parameter int CNT_WIDTH       = $clog2(MAX_OUTSTANDING + 1)
) (
	input  logic                            clk,
	input  logic                            rst_n,

	input  logic                            req_valid_i,
	output logic                            req_ready_o,
	input  logic [ADDR_WIDTH-1:0]           req_addr_i,
	input  logic [DATA_WIDTH-1:0]           req_data_i,

	output logic [ID_WIDTH-1:0]             awid_o,
	output logic [ADDR_WIDTH-1:0]           awaddr_o,
	output logic                            awvalid_o,
	input  logic                            awready_i,

	output logic [ID_WIDTH-1:0]             wid_o,
	output logic [DATA_WIDTH-1:0]           wdata_o,
	output logic                            wvalid_o,
	input  logic                            wready_i,

	input  logic [ID_WIDTH-1:0]             bid_i,
	input  logic [1:0]                      bresp_i,
	input  logic                            bvalid_i,
	output logic                            bready_o,

	output logic [CNT_WIDTH-1:0]            outstanding_o,
	output logic [evict_pkg::ERR_WIDTH-1:0] err_count_o
);

	logic                  afifo_full;
	logic                  afifo_empty;
	logic                  afifo_rd_en;
	logic [ADDR_WIDTH-1:0] afifo_data;

	logic                  dfifo_full;
	logic                  dfifo_empty;
	logic                  dfifo_rd_en;
	logic [DATA_WIDTH-1:0] dfifo_data;

	logic                  push;
	logic                  credit_ok;
	logic                  aw_fire;

	// Both FIFOs are pushed together, so their counts always match.
	assign req_ready_o = !afifo_full && !dfifo_full;
	assign push        = req_valid_i && req_ready_o;

	evict_fifo #(
		.WIDTH     (ADDR_WIDTH),
		.DEPTH     (FIFO_DEPTH)
	) u_afifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (push),
		.wr_data_i (req_addr_i),
		.full_o    (afifo_full),
		.rd_en_i   (afifo_rd_en),
		.rd_data_o (afifo_data),
		.empty_o   (afifo_empty)
	);

	evict_fifo #(
		.WIDTH     (DATA_WIDTH),
		.DEPTH     (FIFO_DEPTH)
	) u_dfifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (push),
		.wr_data_i (req_data_i),
		.full_o    (dfifo_full),
		.rd_en_i   (dfifo_rd_en),
		.rd_data_o (dfifo_data),
		.empty_o   (dfifo_empty)
	);

	evict_aw_w #(
		.ADDR_WIDTH    (ADDR_WIDTH),
		.DATA_WIDTH    (DATA_WIDTH),
		.ID_WIDTH      (ID_WIDTH)
	) u_aw_w (
		.clk           (clk),
		.rst_n         (rst_n),
		.awid_o        (awid_o),
		.awaddr_o      (awaddr_o),
		.awvalid_o     (awvalid_o),
		.awready_i     (awready_i),
		.wid_o         (wid_o),
		.wdata_o       (wdata_o),
		.wvalid_o      (wvalid_o),
		.wready_i      (wready_i),
		.afifo_empty_i (afifo_empty),
		.afifo_rd_en_o (afifo_rd_en),
		.afifo_data_i  (afifo_data),
		.dfifo_empty_i (dfifo_empty),
		.dfifo_rd_en_o (dfifo_rd_en),
		.dfifo_data_i  (dfifo_data),
		.credit_ok_i   (credit_ok),
		.aw_fire_o     (aw_fire)
	);

	evict_b_track #(
		.ID_WIDTH        (ID_WIDTH),
		.MAX_OUTSTANDING (MAX_OUTSTANDING),
		.CNT_WIDTH       (CNT_WIDTH)
	) u_b_track (
		.clk             (clk),
		.rst_n           (rst_n),
		.aw_fire_i       (aw_fire),
		.bid_i           (bid_i),
		.bresp_i         (bresp_i),
		.bvalid_i        (bvalid_i),
		.bready_o        (bready_o),
		.credit_ok_o     (credit_ok),
		.outstanding_o   (outstanding_o),
		.err_count_o     (err_count_o)
	);

endmodule

// File: tb_evict.sv
`timescale 1ns/1ps

module tb_evict;

	localparam int ADDR_W     = evict_pkg::ADDR_WIDTH_D;
	localparam int DATA_W     = evict_pkg::DATA_WIDTH_D;
	localparam int ID_W       = evict_pkg::ID_WIDTH_D;
	localparam int FIFO_DEPTH = 8;
	localparam int MAX_OUT    = 4;
	localparam int CNT_W      = $clog2(MAX_OUT + 1);

	localparam int RDY_LOW  = 0;
	localparam int RDY_HIGH = 1;
	localparam int RDY_RAND = 2;

	logic                            clk;
	logic                            rst_n;
	logic                            req_valid_i;
	logic                            req_ready_o;
	logic [ADDR_W-1:0]               req_addr_i;
	logic [DATA_W-1:0]               req_data_i;
	logic [ID_W-1:0]                 awid_o;
	logic [ADDR_W-1:0]               awaddr_o;
	logic                            awvalid_o;
	logic                            awready_i;
	logic [ID_W-1:0]                 wid_o;
	logic [DATA_W-1:0]               wdata_o;
	logic                            wvalid_o;
	logic                            wready_i;
	logic [ID_W-1:0]                 bid_i;
	logic [1:0]                      bresp_i;
	logic                            bvalid_i;
	logic                            bready_o;
	logic [CNT_W-1:0]                outstanding_o;
	logic [evict_pkg::ERR_WIDTH-1:0] err_count_o;

	// Scoreboard and slave model state.
	logic [ADDR_W-1:0] exp_addr[$];
	logic [DATA_W-1:0] exp_data[$];
	logic [31:0]       rng;
	int                model_out;
	int                model_err;
	int                b_pending;
	int                aw_count;
	int                to_send;
	int                accepted;
	int                ready_mode;
	logic              req_always;
	logic              hold_b;
	logic              ready_low_seen;
	logic              aw_held;
	logic              w_held;
	logic [ADDR_W-1:0] held_addr;
	logic [DATA_W-1:0] held_data;

	evict_top #(
		.ADDR_WIDTH      (ADDR_W),
		.DATA_WIDTH      (DATA_W),
		.ID_WIDTH        (ID_W),
		.FIFO_DEPTH      (FIFO_DEPTH),
		.MAX_OUTSTANDING (MAX_OUT)
	) dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid_i   (req_valid_i),
		.req_ready_o   (req_ready_o),
		.req_addr_i    (req_addr_i),
		.req_data_i    (req_data_i),
		.awid_o        (awid_o),
		.awaddr_o      (awaddr_o),
		.awvalid_o     (awvalid_o),
		.awready_i     (awready_i),
		.wid_o         (wid_o),
		.wdata_o       (wdata_o),
		.wvalid_o      (wvalid_o),
		.wready_i      (wready_i),
		.bid_i         (bid_i),
		.bresp_i       (bresp_i),
		.bvalid_i      (bvalid_i),
		.bready_o      (bready_o),
		.outstanding_o (outstanding_o),
		.err_count_o   (err_count_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Errors found");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "run aborted");
	endtask

	task automatic check_reset_state();
		@(posedge clk);
		check_value("awvalid_o", 64'(awvalid_o), 64'(0));
		check_value("wvalid_o", 64'(wvalid_o), 64'(0));
		check_value("outstanding_o", 64'(outstanding_o), 64'(0));
		check_value("err_count_o", 64'(err_count_o), 64'(0));
		check_value("req_ready_o", 64'(req_ready_o), 64'(1));
	endtask

	// Each call observes one edge and then drives the next cycle.
	task automatic step();
		logic [31:0] r;
		logic [31:0] r_addr;
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		@(posedge clk);
		check_value("outstanding_o", 64'(outstanding_o), 64'(model_out));
		check_value("err_count_o", 64'(err_count_o), 64'(model_err));
		if (int'(outstanding_o) > MAX_OUT) begin
			abort_run("outstanding count went above the write limit");
		end
		if (aw_held) begin
			check_value("awvalid_o", 64'(awvalid_o), 64'(1));
			check_value("awaddr_o", 64'(awaddr_o), 64'(held_addr));
		end
		if (w_held) begin
			check_value("wvalid_o", 64'(wvalid_o), 64'(1));
			check_value("wdata_o", 64'(wdata_o), 64'(held_data));
		end
		if (!req_ready_o) begin
			ready_low_seen = 1'b1;
		end
		if (req_valid_i && req_ready_o) begin
			exp_addr.push_back(req_addr_i);
			exp_data.push_back(req_data_i);
			accepted++;
			to_send--;
		end
		if (awvalid_o && awready_i) begin
			if (exp_addr.size() == 0) begin
				abort_run("AW handshake with no request waiting");
			end else begin
				check_value("awaddr_o", 64'(awaddr_o), 64'(exp_addr.pop_front()));
				check_value("awid_o", 64'(awid_o), 64'(evict_pkg::EVICT_ID));
				model_out++;
				b_pending++;
				aw_count++;
			end
		end
		if (wvalid_o && wready_i) begin
			if (exp_data.size() == 0) begin
				abort_run("W handshake with no request waiting");
			end else begin
				check_value("wdata_o", 64'(wdata_o), 64'(exp_data.pop_front()));
				check_value("wid_o", 64'(wid_o), 64'(evict_pkg::EVICT_ID));
			end
		end
		if (bvalid_i) begin
			check_value("bready_o", 64'(bready_o), 64'(1));
			model_out--;
			if (bresp_i != evict_pkg::RESP_OKAY && model_err < 255) begin
				model_err++;
			end
		end
		aw_held   = awvalid_o && !awready_i;
		held_addr = awaddr_o;
		w_held    = wvalid_o && !wready_i;
		held_data = wdata_o;

		rng = xorshift32(rng);
		r = rng;
		rng = xorshift32(rng);
		r_addr = rng;
		rng = xorshift32(rng);
		r_hi = rng;
		rng = xorshift32(rng);
		r_lo = rng;

		// A request that is waiting keeps its payload.
		if (!(req_valid_i && !req_ready_o)) begin
			if (to_send > 0 && (req_always || r[1:0] != 2'b00)) begin
				req_valid_i <= 1'b1;
				req_addr_i  <= r_addr;
				req_data_i  <= {r_hi, r_lo};
			end else begin
				req_valid_i <= 1'b0;
			end
		end
		case (ready_mode)
			RDY_LOW: begin
				awready_i <= 1'b0;
				wready_i  <= 1'b0;
			end
			RDY_HIGH: begin
				awready_i <= 1'b1;
				wready_i  <= 1'b1;
			end
			default: begin
				awready_i <= (r[3:2] != 2'b00);
				wready_i  <= (r[5:4] != 2'b00);
			end
		endcase
		// Slave returns one B per AW after a random delay.
		if (!hold_b && b_pending > 0 && r[6]) begin
			bvalid_i <= 1'b1;
			bresp_i  <= (r[9:8] == 2'b00) ? evict_pkg::RESP_SLVERR : evict_pkg::RESP_OKAY;
			b_pending--;
		end else begin
			bvalid_i <= 1'b0;
		end
	endtask

	task automatic wait_drained(input string phase, input int limit);
		int cycles;
		cycles = 0;
		while (to_send > 0 || exp_addr.size() > 0 || exp_data.size() > 0 ||
				model_out > 0 || b_pending > 0) begin
			if (cycles >= limit) begin
				abort_run($sformatf("timeout while draining %s", phase));
			end else begin
				step();
				cycles++;
			end
		end
	endtask

	initial begin
		int cycles;
		int aw_before;
		int acc_before;
		rst_n       = 1'b0;
		req_valid_i = 1'b0;
		req_addr_i  = '0;
		req_data_i  = '0;
		awready_i   = 1'b0;
		wready_i    = 1'b0;
		bid_i       = evict_pkg::EVICT_ID;
		bresp_i     = evict_pkg::RESP_OKAY;
		bvalid_i    = 1'b0;
		rng         = 32'h6e44;
		model_out   = 0;
		model_err   = 0;
		b_pending   = 0;
		aw_count    = 0;
		to_send     = 0;
		accepted    = 0;
		ready_mode  = RDY_RAND;
		req_always  = 1'b0;
		hold_b      = 1'b0;
		aw_held     = 1'b0;
		w_held      = 1'b0;
		held_addr   = '0;
		held_data   = '0;
		ready_low_seen = 1'b0;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_state();

		// Random traffic with ready stalls and random B responses.
		to_send = 80;
		wait_drained("random traffic", 4000);

		// Withheld B responses stop issue at the write limit.
		hold_b     = 1'b1;
		ready_mode = RDY_HIGH;
		req_always = 1'b1;
		to_send    = 10;
		cycles     = 0;
		while (model_out < MAX_OUT) begin
			if (cycles >= 300) begin
				abort_run("timeout waiting for the write limit");
			end else begin
				step();
				cycles++;
			end
		end
		aw_before = aw_count;
		repeat (30) step();
		check_value("aw handshake count", 64'(aw_count), 64'(aw_before));
		hold_b = 1'b0;
		wait_drained("credit limit", 1000);

		// Both readys low until the FIFOs fill.
		ready_mode     = RDY_LOW;
		accepted       = 0;
		ready_low_seen = 1'b0;
		to_send        = FIFO_DEPTH + 4;
		cycles         = 0;
		while (!ready_low_seen) begin
			if (cycles >= 100) begin
				abort_run("timeout waiting for req_ready_o to fall");
			end else begin
				step();
				cycles++;
			end
		end
		check_value("accepted requests", 64'(accepted), 64'(FIFO_DEPTH + 1));
		acc_before = accepted;
		repeat (10) step();
		check_value("accepted requests", 64'(accepted), 64'(acc_before));
		ready_mode = RDY_RAND;
		req_always = 1'b0;
		wait_drained("back-pressure", 2000);

		$display("No errors");
		$finish;
	end

endmodule

// File: verilog.f
evict_pkg.sv
evict_fifo.sv
evict_aw_w.sv
evict_b_track.sv
evict_top.sv
tb_evict.sv

// File: run.sh
#!/bin/sh
# Build the eviction path testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_evict -o sim_evict
./obj_dir/sim_evict
